// ==== Bender.yml ====
package:
  name: merge_engine

sources:
  - merge_engine_pkg.sv
  - merge_config_decode.sv
  - merge_field_execute.sv
  - merge_result_fifo.sv
  - merge_engine.sv
  - target: test
    files:
      - merge_engine_assert.sv
      - merge_engine_tb.sv

// ==== merge_config_decode.sv ====
// merge configuration decode
`timescale 1ns/1ps
`default_nettype none

module merge_config_decode
    import merge_engine_pkg::*;
(
    input  wire logic                  ap_clk,
    input  wire logic                  areset_fifo,
    input  wire logic                  response_valid,
    input  wire logic [OFFSET_W-1:0]   response_offset,
    input  wire merge_word_u           response_data,
    output logic      [CFG_MASK_W-1:0] cfg_merge_mask,
    output logic      [CFG_MASK_W-1:0] cfg_merge_type,
    output logic      [CFG_OPS_W-1:0]  cfg_ops_mask,
    output logic                       config_ready
);

    // registered response
    logic                  resp_valid_reg;
    logic [OFFSET_W-1:0]   resp_offset_reg;
    merge_word_u           resp_data_reg;

    // one-hot sequence position, all zero while idle
    logic [CFG_SEQ_LEN-1:0] seq_pos;
    logic [CFG_SEQ_LEN-1:0] seq_pos_next;

    logic in_window;
    logic accept;
    logic seq_idle;
    logic seq_done;
    logic seq_start;
    logic seq_advance;

    // shadow copy, filled word by word
    logic [CFG_MASK_W-1:0] shadow_merge_mask;
    logic [CFG_MASK_W-1:0] shadow_merge_type;
    logic [CFG_OPS_W-1:0]  shadow_ops_mask;

    // ------------------------------------------------------------
    // input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            resp_valid_reg <= 1'b0;
        end else begin
            resp_valid_reg <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_offset_reg <= response_offset;
        resp_data_reg   <= response_data;
    end

    // ------------------------------------------------------------
    // window filter and position tracking
    // ------------------------------------------------------------
    assign in_window = (resp_offset_reg >= CFG_SEQ_MIN) && (resp_offset_reg < CFG_SEQ_MAX);
    assign accept    = resp_valid_reg & in_window;
    assign seq_idle  = ~|seq_pos;
    assign seq_done  = seq_pos[CFG_SEQ_LEN-1];

    // a new sequence may open right on the completing cycle
    assign seq_start   = accept & (resp_offset_reg == CFG_SEQ_MIN) & (seq_idle | seq_done);
    // in-order assumption, offset of a later word is not checked
    assign seq_advance = accept & ~seq_idle & ~seq_done;

    always_comb begin
        seq_pos_next = seq_pos;
        if (seq_start) begin
            seq_pos_next = CFG_SEQ_LEN'(1);
        end else if (seq_done) begin
            seq_pos_next = '0;
        end else if (seq_advance) begin
            seq_pos_next = seq_pos << 1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            seq_pos <= '0;
        end else begin
            seq_pos <= seq_pos_next;
        end
    end

    // capture by the position the word lands on, reserved words fall through
    always_ff @(posedge ap_clk) begin
        if (seq_start) begin
            shadow_merge_mask <= resp_data_reg.cfg.mask;
        end else if (seq_advance && seq_pos_next[1]) begin
            shadow_merge_type <= resp_data_reg.cfg.mask;
        end else if (seq_advance && seq_pos_next[2]) begin
            shadow_ops_mask <= {resp_data_reg.cfg.ops_hi, resp_data_reg.cfg.mask};
        end
    end

    // ------------------------------------------------------------
    // apply on completion
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            cfg_merge_mask <= '0;
            cfg_merge_type <= '0;
            cfg_ops_mask   <= '0;
            config_ready   <= 1'b0;
        end else begin
            if (seq_done) begin
                cfg_merge_mask <= shadow_merge_mask;
                cfg_merge_type <= shadow_merge_type;
                cfg_ops_mask   <= shadow_ops_mask;
            end
            if (seq_start) begin
                config_ready <= 1'b0;
            end else if (seq_done) begin
                config_ready <= 1'b1;
            end
        end
    end

endmodule : merge_config_decode

`default_nettype wire

// ==== merge_engine.f ====
merge_engine_pkg.sv
merge_config_decode.sv
merge_field_execute.sv
merge_result_fifo.sv
merge_engine.sv
merge_engine_assert.sv
merge_engine_tb.sv

// ==== merge_engine.sv ====
// merge engine top level
`timescale 1ns/1ps
`default_nettype none

module merge_engine
    import merge_engine_pkg::*;
(
    input  wire logic                ap_clk,
    input  wire logic                areset_fifo,
    input  wire logic                response_valid,
    input  wire logic [OFFSET_W-1:0] response_offset,
    input  wire logic [WORD_W-1:0]   response_data,
    input  wire logic                packet_valid,
    input  wire logic [WORD_W-1:0]   packet_data,
    input  wire logic                result_rd_en,
    output logic                     result_valid,
    output logic      [WORD_W-1:0]   result_data,
    output logic                     result_empty,
    output logic                     result_prog_full,
    output logic                     config_ready,
    output logic                     setup
);

    // decode to execute
    logic [CFG_MASK_W-1:0] cfg_merge_mask;
    logic [CFG_MASK_W-1:0] cfg_merge_type;
    logic [CFG_OPS_W-1:0]  cfg_ops_mask;

    // execute to result
    logic        push;
    merge_word_u push_data;

    // ------------------------------------------------------------
    // setup level, high in reset and one cycle after
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            setup <= 1'b1;
        end else begin
            setup <= 1'b0;
        end
    end

    merge_config_decode u_decode (
        .ap_clk          (ap_clk),
        .areset_fifo     (areset_fifo),
        .response_valid  (response_valid),
        .response_offset (response_offset),
        .response_data   (response_data),
        .cfg_merge_mask  (cfg_merge_mask),
        .cfg_merge_type  (cfg_merge_type),
        .cfg_ops_mask    (cfg_ops_mask),
        .config_ready    (config_ready)
    );

    merge_field_execute u_execute (
        .ap_clk         (ap_clk),
        .areset_fifo    (areset_fifo),
        .packet_valid   (packet_valid),
        .packet_data    (packet_data),
        .cfg_merge_mask (cfg_merge_mask),
        .cfg_merge_type (cfg_merge_type),
        .cfg_ops_mask   (cfg_ops_mask),
        .push           (push),
        .push_data      (push_data)
    );

    merge_result_fifo u_result (
        .ap_clk           (ap_clk),
        .areset_fifo      (areset_fifo),
        .push             (push),
        .push_data        (push_data),
        .result_rd_en     (result_rd_en),
        .result_valid     (result_valid),
        .result_data      (result_data),
        .result_empty     (result_empty),
        .result_prog_full (result_prog_full)
    );

endmodule : merge_engine

`default_nettype wire

// ==== merge_engine_assert.sv ====
// merge engine port assertions
`timescale 1ns/1ps
`default_nettype none

module merge_engine_assert (
    input wire logic ap_clk,
    input wire logic areset_fifo,
    input wire logic result_rd_en,
    input wire logic result_valid,
    input wire logic result_empty,
    input wire logic result_prog_full,
    input wire logic config_ready
);

    // ------------------------------------------------------------
    // result port
    // ------------------------------------------------------------
    // a result only follows a read of a non-empty queue
    assert property (@(posedge ap_clk) disable iff (areset_fifo)
        result_valid |-> $past(result_rd_en && !result_empty))
        else $error("result_valid without a read of a non-empty queue");

    assert property (@(posedge ap_clk) !(result_empty && result_prog_full))
        else $error("result_empty and result_prog_full high together");

    // configuration starts cleared
    assert property (@(posedge ap_clk) areset_fifo |=> !config_ready)
        else $error("config_ready high in the cycle after reset");

endmodule : merge_engine_assert

bind merge_engine merge_engine_assert assert_i (
    .ap_clk           (ap_clk),
    .areset_fifo      (areset_fifo),
    .result_rd_en     (result_rd_en),
    .result_valid     (result_valid),
    .result_empty     (result_empty),
    .result_prog_full (result_prog_full),
    .config_ready     (config_ready)
);

`default_nettype wire

// ==== merge_engine_pkg.sv ====
// merge engine shared definitions
`default_nettype none

package merge_engine_pkg;

    // ------------------------------------------------------------
    // packet geometry
    // ------------------------------------------------------------
    // fields per packet word
    localparam int NUM_FIELDS = 4;
    // bits per field
    localparam int FIELD_W = 8;
    // response and packet word width
    localparam int WORD_W = NUM_FIELDS * FIELD_W;
    // response offset width
    localparam int OFFSET_W = 8;

    // ------------------------------------------------------------
    // configuration sequence
    // ------------------------------------------------------------
    // words in one configuration sequence
    localparam int CFG_SEQ_LEN = 16;
    // first offset of this lane's window
    localparam int CFG_SEQ_MIN = 32;
    // one past the last offset of the window
    localparam int CFG_SEQ_MAX = CFG_SEQ_MIN + CFG_SEQ_LEN;
    // merge mask and merge type, one bit per field
    localparam int CFG_MASK_W = NUM_FIELDS;
    // ops mask, one bit per (output field, input field) pair
    localparam int CFG_OPS_W = NUM_FIELDS * NUM_FIELDS;

    // ------------------------------------------------------------
    // result queue
    // ------------------------------------------------------------
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    // occupancy at which prog_full rises
    localparam int PROG_THRESH = 8;

    // ------------------------------------------------------------
    // response / packet word
    // ------------------------------------------------------------
    // same 32 bits seen as a field packet or as a configuration word.
    // mask sits in the low bits, ops is the low 16 bits as {ops_hi, mask}
    typedef union packed {
        logic [NUM_FIELDS-1:0][FIELD_W-1:0] fields;
        struct packed {
            logic [WORD_W-CFG_OPS_W-1:0]     unused;
            logic [CFG_OPS_W-CFG_MASK_W-1:0] ops_hi;
            logic [CFG_MASK_W-1:0]           mask;
        } cfg;
    } merge_word_u;

endpackage : merge_engine_pkg

`default_nettype wire

// ==== merge_engine_tb.sv ====
// merge engine testbench
`timescale 1ns/1ps
`default_nettype none

module merge_engine_tb
    import merge_engine_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROWS       = 9;
    localparam int MAX_PKTS       = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 120 + 500;

    logic                ap_clk;
    logic                areset_fifo;
    logic                response_valid;
    logic [OFFSET_W-1:0] response_offset;
    logic [WORD_W-1:0]   response_data;
    logic                packet_valid;
    logic [WORD_W-1:0]   packet_data;
    logic                result_rd_en;
    logic                result_valid;
    logic [WORD_W-1:0]   result_data;
    logic                result_empty;
    logic                result_prog_full;
    logic                config_ready;
    logic                setup;

    // stimulus table with one configuration triple and its packets per row
    logic [WORD_W-1:0] row_mask [NUM_ROWS];
    logic [WORD_W-1:0] row_type [NUM_ROWS];
    logic [WORD_W-1:0] row_ops  [NUM_ROWS];
    int                row_npkt [NUM_ROWS];
    bit                row_hold [NUM_ROWS];
    logic [WORD_W-1:0] row_pkt  [NUM_ROWS][MAX_PKTS];
    logic [WORD_W-1:0] row_exp  [NUM_ROWS][MAX_PKTS];

    // results expected from the queue in send order
    logic [WORD_W-1:0] exp_q [$];
    int unsigned       seed_val;
    int                cycle_count = 0;

    merge_engine dut_i (
        .ap_clk           (ap_clk),
        .areset_fifo      (areset_fifo),
        .response_valid   (response_valid),
        .response_offset  (response_offset),
        .response_data    (response_data),
        .packet_valid     (packet_valid),
        .packet_data      (packet_data),
        .result_rd_en     (result_rd_en),
        .result_valid     (result_valid),
        .result_data      (result_data),
        .result_empty     (result_empty),
        .result_prog_full (result_prog_full),
        .config_ready     (config_ready),
        .setup            (setup)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not respond within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] expected);
        if (got !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // reference model of the merge rule
    // ------------------------------------------------------------
    function automatic logic [WORD_W-1:0] merge_ref(input logic [WORD_W-1:0] mask_w,
            input logic [WORD_W-1:0] type_w, input logic [WORD_W-1:0] ops_w,
            input logic [WORD_W-1:0] pkt);
        logic [WORD_W-1:0]  res;
        logic [FIELD_W-1:0] fld;
        logic [FIELD_W-1:0] acc_sum;
        logic [FIELD_W-1:0] acc_max;
        res = '0;
        for (int i = 0; i < NUM_FIELDS; i++) begin
            acc_sum = '0;
            acc_max = '0;
            for (int j = 0; j < NUM_FIELDS; j++) begin
                if (mask_w[j] && ops_w[i * NUM_FIELDS + j]) begin
                    fld = pkt[j * FIELD_W +: FIELD_W];
                    acc_sum = acc_sum + fld;
                    if (fld > acc_max) begin
                        acc_max = fld;
                    end
                end
            end
            res[i * FIELD_W +: FIELD_W] = type_w[i] ? acc_max : acc_sum;
        end
        return res;
    endfunction

    task automatic set_row(input int idx, input logic [WORD_W-1:0] mask_w,
            input logic [WORD_W-1:0] type_w, input logic [WORD_W-1:0] ops_w,
            input int npkt, input bit hold);
        row_mask[idx] = mask_w;
        row_type[idx] = type_w;
        row_ops[idx]  = ops_w;
        row_npkt[idx] = npkt;
        row_hold[idx] = hold;
        for (int k = 0; k < npkt; k++) begin
            row_pkt[idx][k] = $urandom();
        end
    endtask

    // ------------------------------------------------------------
    // drivers called on a falling edge
    // ------------------------------------------------------------
    task automatic send_response(input logic [OFFSET_W-1:0] offset,
                                 input logic [WORD_W-1:0] data);
        response_valid  = 1'b1;
        response_offset = offset;
        response_data   = data;
        @(negedge ap_clk);
        response_valid  = 1'b0;
    endtask

    // offset below or above the lane window
    task automatic send_noise();
        logic [OFFSET_W-1:0] off;
        off = OFFSET_W'($urandom_range(255, CFG_SEQ_MIN + CFG_SEQ_LEN));
        if ($urandom_range(1, 0) == 1) begin
            off = OFFSET_W'($urandom_range(CFG_SEQ_MIN - 1, 0));
        end
        send_response(off, $urandom());
    endtask

    task automatic send_sequence(input int row);
        logic [WORD_W-1:0] word;
        for (int p = 0; p < CFG_SEQ_LEN; p++) begin
            if ($urandom_range(1, 0) == 1) begin
                send_noise();
            end
            case (p)
                0:       word = row_mask[row];
                1:       word = row_type[row];
                2:       word = row_ops[row];
                default: word = $urandom();
            endcase
            send_response(OFFSET_W'(CFG_SEQ_MIN + p), word);
        end
        // config_ready dropped by the new sequence and not yet raised
        check_value("config_ready", config_ready, 1'b0);
        while (config_ready !== 1'b1) begin
            @(negedge ap_clk);
        end
    endtask

    task automatic send_packets(input int row);
        for (int k = 0; k < row_npkt[row]; k++) begin
            packet_valid = 1'b1;
            packet_data  = row_pkt[row][k];
            exp_q.push_back(row_exp[row][k]);
            @(negedge ap_clk);
            packet_valid = 1'b0;
        end
        // push lands two cycles after the last packet
        repeat (2) @(negedge ap_clk);
        check_value("result_prog_full", result_prog_full, exp_q.size() >= PROG_THRESH);
        check_value("result_empty", result_empty, exp_q.size() == 0);
    endtask

    task automatic drain_results();
        logic [WORD_W-1:0] exp_word;
        while (exp_q.size() > 0) begin
            // occupancy equals the entries still expected
            check_value("result_prog_full", result_prog_full, exp_q.size() >= PROG_THRESH);
            exp_word = exp_q.pop_front();
            result_rd_en = 1'b1;
            @(negedge ap_clk);
            result_rd_en = 1'b0;
            while (result_valid !== 1'b1) begin
                @(negedge ap_clk);
            end
            check_value("result_data", result_data, exp_word);
        end
        check_value("result_empty", result_empty, 1'b1);
        // read on an empty queue
        result_rd_en = 1'b1;
        @(negedge ap_clk);
        result_rd_en = 1'b0;
        check_value("result_valid", result_valid, 1'b0);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        areset_fifo     = 1'b1;
        response_valid  = 1'b0;
        response_offset = '0;
        response_data   = '0;
        packet_valid    = 1'b0;
        packet_data     = '0;
        result_rd_en    = 1'b0;
        seed_val        = $urandom(32'hfcc3);

        set_row(0, 32'h0000_000f, 32'h0000_0000, 32'h0000_ffff, 4, 1'b0);
        row_pkt[0][0] = 32'hffff_ffff;
        set_row(1, 32'h0000_000f, 32'h0000_000f, 32'h0000_ffff, 4, 1'b0);
        row_pkt[1][0] = 32'h01fe_7f80;
        set_row(2, 32'h7700_000b, 32'h0080_0006, 32'h1234_3c5a, 4, 1'b0);
        set_row(3, 32'h0000_0005, 32'h0000_000a, 32'h0000_0a05, 4, 1'b0);
        set_row(4, 32'h0000_000f, 32'h0000_0003, 32'h0000_1248, 10, 1'b0);
        set_row(5, 32'h0000_0003, 32'h0000_0000, 32'h0000_3333, 3, 1'b1);
        set_row(6, 32'h0000_000f, 32'h0000_000f, 32'h0000_cccc, 3, 1'b0);
        set_row(7, $urandom(), $urandom(), $urandom(), 6, 1'b0);
        set_row(8, $urandom(), $urandom(), $urandom(), 6, 1'b0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < row_npkt[r]; k++) begin
                row_exp[r][k] = merge_ref(row_mask[r], row_type[r], row_ops[r], row_pkt[r][k]);
            end
        end

        repeat (RESET_CYCLES) @(negedge ap_clk);
        check_value("result_empty", result_empty, 1'b1);
        check_value("result_valid", result_valid, 1'b0);
        check_value("config_ready", config_ready, 1'b0);
        check_value("setup", setup, 1'b1);
        areset_fifo = 1'b0;
        @(negedge ap_clk);
        check_value("setup", setup, 1'b0);
        check_value("config_ready", config_ready, 1'b0);

        // out-of-window words leave the configuration cleared
        for (int p = 0; p < CFG_SEQ_LEN; p++) begin
            send_response(OFFSET_W'(CFG_SEQ_MIN + CFG_SEQ_LEN + p), 32'hffff_ffff);
            send_response(OFFSET_W'(p), 32'hffff_ffff);
        end
        repeat (4) @(negedge ap_clk);
        check_value("config_ready", config_ready, 1'b0);
        packet_valid = 1'b1;
        packet_data  = 32'h1234_5678;
        exp_q.push_back('0);
        @(negedge ap_clk);
        packet_valid = 1'b0;
        repeat (2) @(negedge ap_clk);
        drain_results();

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_sequence(r);
            send_packets(r);
            if (!row_hold[r]) begin
                drain_results();
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule : merge_engine_tb

`default_nettype wire

// ==== merge_field_execute.sv ====
// field merge pipeline
`timescale 1ns/1ps
`default_nettype none

module merge_field_execute
    import merge_engine_pkg::*;
(
    input  wire logic                  ap_clk,
    input  wire logic                  areset_fifo,
    input  wire logic                  packet_valid,
    input  wire merge_word_u           packet_data,
    input  wire logic [CFG_MASK_W-1:0] cfg_merge_mask,
    input  wire logic [CFG_MASK_W-1:0] cfg_merge_type,
    input  wire logic [CFG_OPS_W-1:0]  cfg_ops_mask,
    output logic                       push,
    output merge_word_u                push_data
);

    // stage 1 state
    logic                                s1_valid;
    merge_word_u                         s1_packet;
    // s1_select[i][j] set when input field j feeds output field i
    logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] s1_select;
    logic [CFG_MASK_W-1:0]               s1_type;

    // stage 2 combinational result
    merge_word_u merged;

    // ------------------------------------------------------------
    // stage 1, register packet and selection
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= packet_valid;
        end
    end

    // config is sampled here so in-flight packets keep their setting
    always_ff @(posedge ap_clk) begin
        s1_packet <= packet_data;
        s1_type   <= cfg_merge_type;
        for (int i = 0; i < NUM_FIELDS; i++) begin
            for (int j = 0; j < NUM_FIELDS; j++) begin
                s1_select[i][j] <= cfg_merge_mask[j] & cfg_ops_mask[i*NUM_FIELDS+j];
            end
        end
    end

    // ------------------------------------------------------------
    // stage 2, reduce by sum or max
    // ------------------------------------------------------------
    always_comb begin
        logic [FIELD_W-1:0] sum_acc;
        logic [FIELD_W-1:0] max_acc;
        merged = '0;
        for (int i = 0; i < NUM_FIELDS; i++) begin
            sum_acc = '0;
            max_acc = '0;
            for (int j = 0; j < NUM_FIELDS; j++) begin
                if (s1_select[i][j]) begin
                    // wraps modulo 256
                    sum_acc = sum_acc + s1_packet.fields[j];
                    if (s1_packet.fields[j] > max_acc) begin
                        max_acc = s1_packet.fields[j];
                    end
                end
            end
            // empty selection leaves both at zero
            merged.fields[i] = s1_type[i] ? max_acc : sum_acc;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            push <= 1'b0;
        end else begin
            push <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_data <= merged;
    end

endmodule : merge_field_execute

`default_nettype wire

// ==== merge_result_fifo.sv ====
// merge result queue
`timescale 1ns/1ps
`default_nettype none

module merge_result_fifo
    import merge_engine_pkg::*;
(
    input  wire logic              ap_clk,
    input  wire logic              areset_fifo,
    input  wire logic              push,
    input  wire merge_word_u       push_data,
    input  wire logic              result_rd_en,
    output logic                   result_valid,
    output logic      [WORD_W-1:0] result_data,
    output logic                   result_empty,
    output logic                   result_prog_full
);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    // one extra bit so a full queue is distinct from empty
    logic [FIFO_PTR_W:0]   count;

    logic full;
    logic do_push;
    logic do_pop;

    // ------------------------------------------------------------
    // status
    // ------------------------------------------------------------
    assign full             = (count == FIFO_DEPTH);
    assign result_empty     = (count == '0);
    assign result_prog_full = (count >= PROG_THRESH);

    // push while full is lost, read while empty is ignored
    assign do_push = push & ~full;
    assign do_pop  = result_rd_en & ~result_empty;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // storage and registered read port
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= do_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_pop) begin
            result_data <= mem[rd_ptr];
        end
    end

endmodule : merge_result_fifo

`default_nettype wire
